//--- chan_bypass_queue.sv
`timescale 1ns/100ps
`default_nettype none

// One-deep queue that passes data straight through while the far side
// keeps up, and parks a single payload when it does not
module chan_bypass_queue #(
    parameter int DATA_W = 8
) (
    input  wire logic              clk,
    input  wire logic              rst,

    input  wire logic              in_valid_i,
    output logic                   in_ready_o,
    input  wire logic [DATA_W-1:0] in_data_i,

    output logic                   out_valid_o,
    input  wire logic              out_ready_i,
    output logic [DATA_W-1:0]      out_data_o
);

    logic              full;
    logic              load;
    logic [DATA_W-1:0] hold_q;

    // Accepted upstream but the downstream did not take it
    assign load = in_valid_i && !full && !out_ready_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            full <= 1'b0;
        end else if (full) begin
            // Drains on a downstream transfer
            full <= !out_ready_i;
        end else begin
            full <= load;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            hold_q <= in_data_i;
        end
    end

    assign in_ready_o = !full;

    assign out_valid_o = in_valid_i || full;

    // Held payload is older, so it goes first
    assign out_data_o = full ? hold_q : in_data_i;

endmodule

`default_nettype wire

//--- llc_cfg.svh
`ifndef LLC_CFG_SVH
`define LLC_CFG_SVH

// Field widths shared by the channel front end

// Line address, tag plus set index
`define LLC_ADDR_W 28

// One cache line of payload
`define LLC_LINE_W 128

// Requester and destination node id
`define LLC_ID_W 4

// Word position inside a line
`define LLC_WOFF_W 2

// Invalidation acknowledge counter
`define LLC_INVACK_W 4

// Memory transfer size code
`define LLC_HSIZE_W 3

`endif

//--- llc_channels.sv
`timescale 1ns/100ps
`default_nettype none

// Channel front end of the last-level cache controller
module llc_channels (
    input  wire logic                        clk,
    input  wire logic                        rst,

    input  wire logic                        req_valid_i,
    output logic                             req_ready_o,
    input  wire llc_msg_pkg::llc_req_t       req_i,
    output logic                             req_pop_valid_o,
    input  wire logic                        req_pop_ready_i,
    output llc_msg_pkg::llc_req_t            req_o,
    input  wire logic                        stall_save_i,
    input  wire logic                        stall_restore_i,
    output llc_coh_pkg::line_addr_t          req_addr_o,

    input  wire logic                        rsp_valid_i,
    output logic                             rsp_ready_o,
    input  wire llc_msg_pkg::llc_rsp_in_t    rsp_i,
    output logic                             rsp_pop_valid_o,
    input  wire logic                        rsp_pop_ready_i,
    output llc_msg_pkg::llc_rsp_in_t         rsp_o,
    output llc_coh_pkg::line_addr_t          rsp_addr_o,

    input  wire logic                        mem_rsp_valid_i,
    output logic                             mem_rsp_ready_o,
    input  wire llc_msg_pkg::llc_mem_rsp_t   mem_rsp_i,
    output logic                             mem_rsp_pop_valid_o,
    input  wire logic                        mem_rsp_pop_ready_i,
    output llc_msg_pkg::llc_mem_rsp_t        mem_rsp_o,

    input  wire logic                        rsp_out_valid_i,
    output logic                             rsp_out_ready_o,
    input  wire llc_msg_pkg::llc_rsp_out_t   rsp_out_i,
    output logic                             rsp_out_valid_o,
    input  wire logic                        rsp_out_ready_i,
    output llc_msg_pkg::llc_rsp_out_t        rsp_out_o,

    input  wire logic                        mem_req_valid_i,
    output logic                             mem_req_ready_o,
    input  wire llc_msg_pkg::llc_mem_req_t   mem_req_i,
    output logic                             mem_req_valid_o,
    input  wire logic                        mem_req_ready_i,
    output llc_msg_pkg::llc_mem_req_t        mem_req_o
);

    // Network and memory toward the controller
    llc_input_side u_input_side (
        .clk                (clk),
        .rst                (rst),
        .req_valid_i        (req_valid_i),
        .req_ready_o        (req_ready_o),
        .req_i              (req_i),
        .req_pop_valid_o    (req_pop_valid_o),
        .req_pop_ready_i    (req_pop_ready_i),
        .req_o              (req_o),
        .stall_save_i       (stall_save_i),
        .stall_restore_i    (stall_restore_i),
        .req_addr_o         (req_addr_o),
        .rsp_valid_i        (rsp_valid_i),
        .rsp_ready_o        (rsp_ready_o),
        .rsp_i              (rsp_i),
        .rsp_pop_valid_o    (rsp_pop_valid_o),
        .rsp_pop_ready_i    (rsp_pop_ready_i),
        .rsp_o              (rsp_o),
        .rsp_addr_o         (rsp_addr_o),
        .mem_rsp_valid_i    (mem_rsp_valid_i),
        .mem_rsp_ready_o    (mem_rsp_ready_o),
        .mem_rsp_i          (mem_rsp_i),
        .mem_rsp_pop_valid_o(mem_rsp_pop_valid_o),
        .mem_rsp_pop_ready_i(mem_rsp_pop_ready_i),
        .mem_rsp_o          (mem_rsp_o)
    );

    // Controller toward network and memory
    llc_output_side u_output_side (
        .clk            (clk),
        .rst            (rst),
        .rsp_out_valid_i(rsp_out_valid_i),
        .rsp_out_ready_o(rsp_out_ready_o),
        .rsp_out_i      (rsp_out_i),
        .rsp_out_valid_o(rsp_out_valid_o),
        .rsp_out_ready_i(rsp_out_ready_i),
        .rsp_out_o      (rsp_out_o),
        .mem_req_valid_i(mem_req_valid_i),
        .mem_req_ready_o(mem_req_ready_o),
        .mem_req_i      (mem_req_i),
        .mem_req_valid_o(mem_req_valid_o),
        .mem_req_ready_i(mem_req_ready_i),
        .mem_req_o      (mem_req_o)
    );

endmodule

`default_nettype wire

//--- llc_coh_pkg.sv
`default_nettype none

`include "llc_cfg.svh"

package llc_coh_pkg;

    // Coherence message kinds, requests first then responses
    typedef enum logic [2:0] {
        COH_GETS   = 3'd0,
        COH_GETM   = 3'd1,
        COH_PUTS   = 3'd2,
        COH_PUTM   = 3'd3,
        COH_DATA   = 3'd4,
        COH_EDATA  = 3'd5,
        COH_INVACK = 3'd6,
        COH_PUTACK = 3'd7
    } coh_msg_t;

    // Set for data access, clear for opcode fetch
    typedef logic hprot_t;

    typedef logic [`LLC_ADDR_W-1:0] line_addr_t;

    typedef logic [`LLC_ID_W-1:0] cache_id_t;

    typedef logic [`LLC_WOFF_W-1:0] word_offset_t;

endpackage

`default_nettype wire

//--- llc_input_side.sv
`timescale 1ns/100ps
`default_nettype none

module llc_input_side (
    input  wire logic                        clk,
    input  wire logic                        rst,

    // Coherence requests
    input  wire logic                        req_valid_i,
    output logic                             req_ready_o,
    input  wire llc_msg_pkg::llc_req_t       req_i,
    output logic                             req_pop_valid_o,
    input  wire logic                        req_pop_ready_i,
    output llc_msg_pkg::llc_req_t            req_o,
    input  wire logic                        stall_save_i,
    input  wire logic                        stall_restore_i,
    output llc_coh_pkg::line_addr_t          req_addr_o,

    // Coherence responses
    input  wire logic                        rsp_valid_i,
    output logic                             rsp_ready_o,
    input  wire llc_msg_pkg::llc_rsp_in_t    rsp_i,
    output logic                             rsp_pop_valid_o,
    input  wire logic                        rsp_pop_ready_i,
    output llc_msg_pkg::llc_rsp_in_t         rsp_o,
    output llc_coh_pkg::line_addr_t          rsp_addr_o,

    // Memory responses
    input  wire logic                        mem_rsp_valid_i,
    output logic                             mem_rsp_ready_o,
    input  wire llc_msg_pkg::llc_mem_rsp_t   mem_rsp_i,
    output logic                             mem_rsp_pop_valid_o,
    input  wire logic                        mem_rsp_pop_ready_i,
    output llc_msg_pkg::llc_mem_rsp_t        mem_rsp_o
);

    llc_msg_pkg::llc_req_t     req_head;
    llc_msg_pkg::llc_req_t     req_stalled;
    llc_msg_pkg::llc_rsp_in_t  rsp_head;
    llc_msg_pkg::llc_mem_rsp_t mem_rsp_head;

    chan_bypass_queue #(
        .DATA_W($bits(llc_msg_pkg::llc_req_t))
    ) u_req_queue (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (req_valid_i),
        .in_ready_o (req_ready_o),
        .in_data_i  (req_i),
        .out_valid_o(req_pop_valid_o),
        .out_ready_i(req_pop_ready_i),
        .out_data_o (req_head)
    );

    chan_bypass_queue #(
        .DATA_W($bits(llc_msg_pkg::llc_rsp_in_t))
    ) u_rsp_queue (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (rsp_valid_i),
        .in_ready_o (rsp_ready_o),
        .in_data_i  (rsp_i),
        .out_valid_o(rsp_pop_valid_o),
        .out_ready_i(rsp_pop_ready_i),
        .out_data_o (rsp_head)
    );

    chan_bypass_queue #(
        .DATA_W($bits(llc_msg_pkg::llc_mem_rsp_t))
    ) u_mem_rsp_queue (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (mem_rsp_valid_i),
        .in_ready_o (mem_rsp_ready_o),
        .in_data_i  (mem_rsp_i),
        .out_valid_o(mem_rsp_pop_valid_o),
        .out_ready_i(mem_rsp_pop_ready_i),
        .out_data_o (mem_rsp_head)
    );

    // Captured request, a restore beats a new pop
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_o <= '0;
        end else if (stall_restore_i) begin
            req_o <= req_stalled;
        end else if (req_pop_valid_o && req_pop_ready_i) begin
            req_o <= req_head;
        end
    end

    // Parked copy of a request that could not be served yet
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_stalled <= '0;
        end else if (stall_save_i) begin
            req_stalled <= req_o;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rsp_o <= '0;
        end else if (rsp_pop_valid_o && rsp_pop_ready_i) begin
            rsp_o <= rsp_head;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mem_rsp_o <= '0;
        end else if (mem_rsp_pop_valid_o && mem_rsp_pop_ready_i) begin
            mem_rsp_o <= mem_rsp_head;
        end
    end

    // Early line address for the set lookup
    // a low ready means the queue is holding a message
    assign req_addr_o = req_ready_o ? req_i.addr : req_head.addr;
    assign rsp_addr_o = rsp_ready_o ? rsp_i.addr : rsp_head.addr;

endmodule

`default_nettype wire

//--- llc_msg_pkg.sv
`default_nettype none

`include "llc_cfg.svh"

package llc_msg_pkg;

    typedef logic [`LLC_LINE_W-1:0] line_t;

    // One bit per word of the line
    typedef logic [(1 << `LLC_WOFF_W)-1:0] word_mask_t;

    typedef struct packed {
        llc_coh_pkg::coh_msg_t     coh_msg;
        llc_coh_pkg::hprot_t       hprot;
        llc_coh_pkg::line_addr_t   addr;
        line_t                     line;
        llc_coh_pkg::cache_id_t    req_id;
        llc_coh_pkg::word_offset_t word_offset;
        word_mask_t                valid_words;
    } llc_req_t;

    typedef struct packed {
        llc_coh_pkg::coh_msg_t   coh_msg;
        llc_coh_pkg::line_addr_t addr;
        line_t                   line;
        llc_coh_pkg::cache_id_t  req_id;
    } llc_rsp_in_t;

    typedef struct packed {
        line_t line;
    } llc_mem_rsp_t;

    typedef struct packed {
        llc_coh_pkg::coh_msg_t     coh_msg;
        llc_coh_pkg::line_addr_t   addr;
        line_t                     line;
        logic [`LLC_INVACK_W-1:0]  invack_cnt;
        llc_coh_pkg::cache_id_t    req_id;
        llc_coh_pkg::cache_id_t    dest_id;
        llc_coh_pkg::word_offset_t word_offset;
    } llc_rsp_out_t;

    typedef struct packed {
        logic                     hwrite;
        logic [`LLC_HSIZE_W-1:0]  hsize;
        llc_coh_pkg::hprot_t      hprot;
        llc_coh_pkg::line_addr_t  addr;
        line_t                    line;
    } llc_mem_req_t;

endpackage

`default_nettype wire

//--- llc_output_side.sv
`timescale 1ns/100ps
`default_nettype none

module llc_output_side (
    input  wire logic                        clk,
    input  wire logic                        rst,

    // Responses from the controller toward the network
    input  wire logic                        rsp_out_valid_i,
    output logic                             rsp_out_ready_o,
    input  wire llc_msg_pkg::llc_rsp_out_t   rsp_out_i,
    output logic                             rsp_out_valid_o,
    input  wire logic                        rsp_out_ready_i,
    output llc_msg_pkg::llc_rsp_out_t        rsp_out_o,

    // Memory requests from the controller toward memory
    input  wire logic                        mem_req_valid_i,
    output logic                             mem_req_ready_o,
    input  wire llc_msg_pkg::llc_mem_req_t   mem_req_i,
    output logic                             mem_req_valid_o,
    input  wire logic                        mem_req_ready_i,
    output llc_msg_pkg::llc_mem_req_t        mem_req_o
);

    localparam int RSP_OUT_W = $bits(llc_msg_pkg::llc_rsp_out_t);
    localparam int MEM_REQ_W = $bits(llc_msg_pkg::llc_mem_req_t);

    logic [RSP_OUT_W-1:0] rsp_out_bits;
    logic [MEM_REQ_W-1:0] mem_req_bits;

    chan_bypass_queue #(
        .DATA_W(RSP_OUT_W)
    ) u_rsp_out_queue (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (rsp_out_valid_i),
        .in_ready_o (rsp_out_ready_o),
        .in_data_i  (rsp_out_i),
        .out_valid_o(rsp_out_valid_o),
        .out_ready_i(rsp_out_ready_i),
        .out_data_o (rsp_out_bits)
    );

    chan_bypass_queue #(
        .DATA_W(MEM_REQ_W)
    ) u_mem_req_queue (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (mem_req_valid_i),
        .in_ready_o (mem_req_ready_o),
        .in_data_i  (mem_req_i),
        .out_valid_o(mem_req_valid_o),
        .out_ready_i(mem_req_ready_i),
        .out_data_o (mem_req_bits)
    );

    // Back to message form for the network side
    assign rsp_out_o = llc_msg_pkg::llc_rsp_out_t'(rsp_out_bits);
    assign mem_req_o = llc_msg_pkg::llc_mem_req_t'(mem_req_bits);

endmodule

`default_nettype wire

//--- tb_llc_channels.sv
`timescale 1ns/100ps
`default_nettype none

module tb_llc_channels;

    localparam int NUM_MSGS       = 150;
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int STALL_ROUNDS   = 4;
    localparam int REQ_W          = $bits(llc_msg_pkg::llc_req_t);
    localparam int RSP_W          = $bits(llc_msg_pkg::llc_rsp_in_t);
    localparam int MEM_RSP_W      = $bits(llc_msg_pkg::llc_mem_rsp_t);
    localparam int RSP_OUT_W      = $bits(llc_msg_pkg::llc_rsp_out_t);
    localparam int MEM_REQ_W      = $bits(llc_msg_pkg::llc_mem_req_t);

    logic clk;
    logic rst = 1'b0;

    logic                      req_valid_i = 1'b0;
    logic                      req_ready_o;
    llc_msg_pkg::llc_req_t     req_i = '0;
    logic                      req_pop_valid_o;
    logic                      req_pop_ready_i = 1'b0;
    llc_msg_pkg::llc_req_t     req_o;
    logic                      stall_save_i = 1'b0;
    logic                      stall_restore_i = 1'b0;
    llc_coh_pkg::line_addr_t   req_addr_o;

    logic                      rsp_valid_i = 1'b0;
    logic                      rsp_ready_o;
    llc_msg_pkg::llc_rsp_in_t  rsp_i = '0;
    logic                      rsp_pop_valid_o;
    logic                      rsp_pop_ready_i = 1'b0;
    llc_msg_pkg::llc_rsp_in_t  rsp_o;
    llc_coh_pkg::line_addr_t   rsp_addr_o;

    logic                      mem_rsp_valid_i = 1'b0;
    logic                      mem_rsp_ready_o;
    llc_msg_pkg::llc_mem_rsp_t mem_rsp_i = '0;
    logic                      mem_rsp_pop_valid_o;
    logic                      mem_rsp_pop_ready_i = 1'b0;
    llc_msg_pkg::llc_mem_rsp_t mem_rsp_o;

    logic                      rsp_out_valid_i = 1'b0;
    logic                      rsp_out_ready_o;
    llc_msg_pkg::llc_rsp_out_t rsp_out_i = '0;
    logic                      rsp_out_valid_o;
    logic                      rsp_out_ready_i = 1'b0;
    llc_msg_pkg::llc_rsp_out_t rsp_out_o;

    logic                      mem_req_valid_i = 1'b0;
    logic                      mem_req_ready_o;
    llc_msg_pkg::llc_mem_req_t mem_req_i = '0;
    logic                      mem_req_valid_o;
    logic                      mem_req_ready_i = 1'b0;
    llc_msg_pkg::llc_mem_req_t mem_req_o;

    int           seed = 32'ha347_607d;
    logic         traffic_on = 1'b0;
    int           offered [5];
    int           popped_cnt [5];
    bit           model_full [5];
    logic [255:0] model_data [5];
    logic [255:0] exp_req_o = '0;
    logic [255:0] exp_rsp_o = '0;
    logic [255:0] exp_mem_rsp_o = '0;
    logic [255:0] stalled_model = '0;
    int           restores_with_pop;

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    llc_channels UUT (.*);

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_problem(input string why);
        $display("Failure at %0t ns: %s", $time, why);
        abort_run();
    endtask

    task automatic report_mismatch(input string name, input logic [255:0] expected,
                                   input logic [255:0] actual);
        $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        abort_run();
    endtask

    task automatic check_equal(input string name, input logic [255:0] expected,
                               input logic [255:0] actual);
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    function automatic logic [255:0] random_bits();
        logic [255:0] word;
        for (int i = 0; i < 8; i++) begin
            word[i*32 +: 32] = $random(seed);
        end
        return word;
    endfunction

    // 0 idle, 1 keep the pending message, 2 present a new one
    function automatic int offer_state(input int ch, input logic waiting);
        if (waiting) begin
            return 1;
        end
        if (offered[ch] < NUM_MSGS && ($random(seed) & 3) != 0) begin
            offered[ch]++;
            return 2;
        end
        return 0;
    endfunction

    // Depth-one queue model where a message waits only when accepted and not taken
    task automatic track_channel(
        input  int           ch,
        input  string        ready_name,
        input  string        valid_name,
        input  string        data_name,
        input  logic         in_valid,
        input  logic         in_ready,
        input  logic [255:0] in_data,
        input  logic         out_valid,
        input  logic         out_ready,
        input  logic [255:0] out_data,
        input  logic         data_visible,
        output logic [255:0] head,
        output logic         popped
    );
        logic pushed;
        head = model_full[ch] ? model_data[ch] : in_data;
        check_equal(ready_name, 256'(!model_full[ch]), 256'(in_ready));
        check_equal(valid_name, 256'(in_valid || model_full[ch]), 256'(out_valid));
        if (out_valid && data_visible) begin
            check_equal(data_name, head, out_data);
        end
        pushed = in_valid && in_ready;
        popped = out_valid && out_ready;
        if (pushed && !popped) begin
            model_full[ch] = 1'b1;
            model_data[ch] = in_data;
        end else if (popped && !pushed) begin
            model_full[ch] = 1'b0;
        end
        if (popped) begin
            popped_cnt[ch]++;
        end
    endtask

    task automatic wait_for_pops(input int ch, input int target, input string what);
        int cycles;
        cycles = 0;
        while (popped_cnt[ch] < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_problem({"timeout waiting for ", what, " transfers"});
            end
        end
    endtask

    // Holds restore until one lands together with a pop transfer
    task automatic restore_during_pop();
        int seen;
        int cycles;
        seen = restores_with_pop;
        cycles = 0;
        stall_restore_i <= 1'b1;
        while (restores_with_pop == seen) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_problem("timeout waiting for a restore next to a request pop");
            end
        end
        stall_restore_i <= 1'b0;
    endtask

    always @(posedge clk) begin : producers
        int           st;
        logic [255:0] bits;
        if (rst && traffic_on) begin
            st = offer_state(0, req_valid_i && !req_ready_o);
            bits = random_bits();
            req_valid_i <= (st != 0);
            if (st == 2) begin
                req_i <= bits[REQ_W-1:0];
            end
            st = offer_state(1, rsp_valid_i && !rsp_ready_o);
            bits = random_bits();
            rsp_valid_i <= (st != 0);
            if (st == 2) begin
                rsp_i <= bits[RSP_W-1:0];
            end
            st = offer_state(2, mem_rsp_valid_i && !mem_rsp_ready_o);
            bits = random_bits();
            mem_rsp_valid_i <= (st != 0);
            if (st == 2) begin
                mem_rsp_i <= bits[MEM_RSP_W-1:0];
            end
            st = offer_state(3, rsp_out_valid_i && !rsp_out_ready_o);
            bits = random_bits();
            rsp_out_valid_i <= (st != 0);
            if (st == 2) begin
                rsp_out_i <= bits[RSP_OUT_W-1:0];
            end
            st = offer_state(4, mem_req_valid_i && !mem_req_ready_o);
            bits = random_bits();
            mem_req_valid_i <= (st != 0);
            if (st == 2) begin
                mem_req_i <= bits[MEM_REQ_W-1:0];
            end
            req_pop_ready_i     <= ($random(seed) & 3) != 0;
            rsp_pop_ready_i     <= ($random(seed) & 1) != 0;
            mem_rsp_pop_ready_i <= ($random(seed) & 3) == 0;
            rsp_out_ready_i     <= ($random(seed) & 1) != 0;
            mem_req_ready_i     <= ($random(seed) & 3) == 0;
        end
    end

    // Sampled mid-cycle when everything has settled since the last edge
    always @(negedge clk) begin : scoreboard
        logic [255:0]             head;
        logic                     popped;
        logic [255:0]             next_req;
        llc_msg_pkg::llc_req_t    req_head;
        llc_msg_pkg::llc_rsp_in_t rsp_head;
        if (rst) begin
            check_equal("req_o", exp_req_o, 256'(req_o));
            track_channel(0, "req_ready_o", "req_pop_valid_o", "", req_valid_i, req_ready_o,
                256'(req_i), req_pop_valid_o, req_pop_ready_i, '0, 1'b0, head, popped);
            req_head = head[REQ_W-1:0];
            if (req_pop_valid_o) begin
                check_equal("req_addr_o", 256'(req_head.addr), 256'(req_addr_o));
            end
            // Restore beats a pop in the same cycle
            next_req = exp_req_o;
            if (stall_restore_i) begin
                next_req = stalled_model;
                if (popped) begin
                    restores_with_pop++;
                end
            end else if (popped) begin
                next_req = head;
            end
            if (stall_save_i) begin
                stalled_model = exp_req_o;
            end
            exp_req_o = next_req;

            check_equal("rsp_o", exp_rsp_o, 256'(rsp_o));
            track_channel(1, "rsp_ready_o", "rsp_pop_valid_o", "", rsp_valid_i, rsp_ready_o,
                256'(rsp_i), rsp_pop_valid_o, rsp_pop_ready_i, '0, 1'b0, head, popped);
            rsp_head = head[RSP_W-1:0];
            if (rsp_pop_valid_o) begin
                check_equal("rsp_addr_o", 256'(rsp_head.addr), 256'(rsp_addr_o));
            end
            if (popped) begin
                exp_rsp_o = head;
            end

            check_equal("mem_rsp_o", exp_mem_rsp_o, 256'(mem_rsp_o));
            track_channel(2, "mem_rsp_ready_o", "mem_rsp_pop_valid_o", "", mem_rsp_valid_i,
                mem_rsp_ready_o, 256'(mem_rsp_i), mem_rsp_pop_valid_o, mem_rsp_pop_ready_i,
                '0, 1'b0, head, popped);
            if (popped) begin
                exp_mem_rsp_o = head;
            end

            track_channel(3, "rsp_out_ready_o", "rsp_out_valid_o", "rsp_out_o", rsp_out_valid_i,
                rsp_out_ready_o, 256'(rsp_out_i), rsp_out_valid_o, rsp_out_ready_i,
                256'(rsp_out_o), 1'b1, head, popped);
            track_channel(4, "mem_req_ready_o", "mem_req_valid_o", "mem_req_o", mem_req_valid_i,
                mem_req_ready_o, 256'(mem_req_i), mem_req_valid_o, mem_req_ready_i,
                256'(mem_req_o), 1'b1, head, popped);
        end
    end

    // Held payloads stay put until the network takes them
    assert property (@(posedge clk) disable iff (!rst)
        (rsp_out_valid_o && !rsp_out_ready_i) |=> (rsp_out_valid_o && $stable(rsp_out_o)))
        else report_problem("rsp_out_o dropped or changed before it was taken");
    assert property (@(posedge clk) disable iff (!rst)
        (mem_req_valid_o && !mem_req_ready_i) |=> (mem_req_valid_o && $stable(mem_req_o)))
        else report_problem("mem_req_o dropped or changed before it was taken");

    // Capture registers move only on a pop transfer or a restore
    assert property (@(posedge clk) disable iff (!rst)
        (!(req_pop_valid_o && req_pop_ready_i) && !stall_restore_i) |=> $stable(req_o))
        else report_problem("req_o changed without a pop transfer or a restore");
    assert property (@(posedge clk) disable iff (!rst)
        !(rsp_pop_valid_o && rsp_pop_ready_i) |=> $stable(rsp_o))
        else report_problem("rsp_o changed without a pop transfer");
    assert property (@(posedge clk) disable iff (!rst)
        !(mem_rsp_pop_valid_o && mem_rsp_pop_ready_i) |=> $stable(mem_rsp_o))
        else report_problem("mem_rsp_o changed without a pop transfer");

    initial begin : main_sequence
        repeat (16) begin
            @(posedge clk);
        end
        rst <= 1'b1;
        @(negedge clk);
        // Idle state right after reset
        check_equal("req_pop_valid_o", '0, 256'(req_pop_valid_o));
        check_equal("rsp_pop_valid_o", '0, 256'(rsp_pop_valid_o));
        check_equal("mem_rsp_pop_valid_o", '0, 256'(mem_rsp_pop_valid_o));
        check_equal("rsp_out_valid_o", '0, 256'(rsp_out_valid_o));
        check_equal("mem_req_valid_o", '0, 256'(mem_req_valid_o));
        check_equal("req_ready_o", 256'(1'b1), 256'(req_ready_o));
        check_equal("rsp_ready_o", 256'(1'b1), 256'(rsp_ready_o));
        check_equal("mem_rsp_ready_o", 256'(1'b1), 256'(mem_rsp_ready_o));
        check_equal("rsp_out_ready_o", 256'(1'b1), 256'(rsp_out_ready_o));
        check_equal("mem_req_ready_o", 256'(1'b1), 256'(mem_req_ready_o));
        check_equal("req_o", '0, 256'(req_o));
        check_equal("rsp_o", '0, 256'(rsp_o));
        check_equal("mem_rsp_o", '0, 256'(mem_rsp_o));

        @(posedge clk);
        traffic_on <= 1'b1;
        // Save, let a few requests through, then bring the saved one back
        repeat (STALL_ROUNDS) begin
            @(posedge clk);
            stall_save_i <= 1'b1;
            @(posedge clk);
            stall_save_i <= 1'b0;
            wait_for_pops(0, popped_cnt[0] + 3, "request");
            restore_during_pop();
        end

        wait_for_pops(0, NUM_MSGS, "request");
        wait_for_pops(1, NUM_MSGS, "response");
        wait_for_pops(2, NUM_MSGS, "memory response");
        wait_for_pops(3, NUM_MSGS, "outgoing response");
        wait_for_pops(4, NUM_MSGS, "memory request");
        repeat (3) begin
            @(negedge clk);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
llc_coh_pkg.sv
llc_msg_pkg.sv
chan_bypass_queue.sv
llc_input_side.sv
llc_output_side.sv
llc_channels.sv
tb_llc_channels.sv
